/* verilog/branch_pkg.sv */
// types, enums and helper functions shared by every block of the branch resolution back end
`default_nettype none

package branch_pkg;

	// ==================================================
	// widths and constants
	// ==================================================

	// address width used by all pc carrying records
	parameter int ABITS = 32;
	// fall-through increment in bytes, one instruction
	parameter int INSN_LEN = 6;
	// where the machine goes when nothing better is known
	parameter logic [31:0] RSTPC = 32'hFFFC0000;

	// instruction stream id, zero means no stream
	typedef logic [6:0] pc_stream_t;

	typedef struct packed {
		logic [ABITS-1:0] pc;
		pc_stream_t stream;
	} pc_address_t;

	// ==================================================
	// operation and condition encodings
	// ==================================================

	typedef enum logic [2:0] {
		BK_NONE = 3'd0,
		BK_BCC  = 3'd1,
		BK_BSR  = 3'd2,
		BK_JSR  = 3'd3,
		BK_SYS  = 3'd4,
		BK_RET  = 3'd5,
		BK_ERET = 3'd6
	} br_kind_e;

	// lt and ge compare the operands as signed values
	typedef enum logic [1:0] {
		EQ = 2'd0,
		NE = 2'd1,
		LT = 2'd2,
		GE = 2'd3
	} br_cond_e;

	// one evaluated branch as it sits in the queue
	typedef struct packed {
		br_kind_e kind;
		br_cond_e cond;
		logic md;
		pc_address_t pc;
		// displacement counted in halfwords
		logic signed [23:0] disp;
		logic [ABITS-1:0] argc;
		logic [ABITS-1:0] arga;
		logic [1:0] om;
		logic [5:0] sysno;
		logic bt;
		logic takb;
	} br_entry_t;

	// record handed to the front end
	typedef struct packed {
		pc_address_t misspc;
		pc_address_t dstpc;
		pc_stream_t kept_stream;
		logic miss;
	} redirect_t;

	// ==================================================
	// helpers
	// ==================================================

	// next operating mode, the top mode stays where it is
	function automatic logic [1:0] fn_next_om(input logic [1:0] om);
		fn_next_om = (om == 2'd3) ? 2'd3 : om + 2'd1;
	endfunction

	// taken bit for a condition code applied to two operands
	function automatic logic fn_eval_cond(
		input br_cond_e cond,
		input logic [ABITS-1:0] a,
		input logic [ABITS-1:0] b
	);
		case (cond)
			EQ: fn_eval_cond = (a == b);
			NE: fn_eval_cond = (a != b);
			LT: fn_eval_cond = ($signed(a) < $signed(b));
			default: fn_eval_cond = ($signed(a) >= $signed(b));
		endcase
	endfunction

endpackage

`default_nettype wire

/* verilog/branch_queue.sv */
// show-ahead FIFO between branch capture and redirect, generic over its payload type
`timescale 1ns/1ns
`default_nettype none

module branch_queue
#(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
)
(
	input wire clk,
	input wire rst_n,
	input wire push,
	input wire pop,
	input wire T din,
	output T head,
	output logic empty,
	output logic full
);

	// pointer and count widths, a single slot still needs one pointer bit
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic wr_en;
	logic rd_en;

	// a push into a full queue and a pop from an empty one do nothing
	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));

	// the oldest entry is always on the output
	assign head = mem[rd_ptr];

	// storage, written at the edge and visible the cycle after
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	// pointers wrap by compare so any depth works
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// a push and a pop in the same cycle leave the count alone
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/branch_capture.sv */
// issue stage that evaluates a branch condition and registers the entry for the queue
`timescale 1ns/1ns
`default_nettype none

module branch_capture
	import branch_pkg::*;
#(
	parameter int ABITS = 32
)
(
	input wire clk,
	input wire rst_n,
	input wire issue,
	input wire br_kind_e kind,
	input wire br_cond_e cond,
	input wire md,
	input wire pc_address_t pc,
	input wire [23:0] disp,
	input wire [ABITS-1:0] arga,
	input wire [ABITS-1:0] argb,
	input wire [ABITS-1:0] argc,
	input wire [1:0] om,
	input wire [5:0] sysno,
	input wire bt,
	output logic push,
	output br_entry_t entry
);

	// taken bit of the issued operation
	logic takb;
	// the entry as it will be written on the next edge
	br_entry_t entry_d;

	// only a conditional branch has a condition to test
	// every other kind leaves the taken bit low
	always_comb
	begin
		if (kind == BK_BCC)
			takb = fn_eval_cond(cond, arga, argb);
		else
			takb = 1'b0;
	end

	// pack the raw fields in queue order
	always_comb
	begin
		entry_d.kind = kind;
		entry_d.cond = cond;
		entry_d.md = md;
		entry_d.pc = pc;
		entry_d.disp = disp;
		entry_d.argc = argc;
		entry_d.arga = arga;
		entry_d.om = om;
		entry_d.sysno = sysno;
		entry_d.bt = bt;
		entry_d.takb = takb;
	end

	// push follows issue by one clock
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			push <= 1'b0;
		else
			push <= issue;
	end

	// the entry only matters while push is high
	always_ff @(posedge clk)
	begin
		if (issue)
			entry <= entry_d;
	end

endmodule

`default_nettype wire

/* verilog/branchmiss_pc.sv */
// combinational destination, miss pc and stream bookkeeping for one resolved branch
`timescale 1ns/1ns
`default_nettype none

module branchmiss_pc
	import branch_pkg::*;
#(
	parameter int ABITS = 32
)
(
	input wire br_entry_t ent,
	input wire pc_stream_t new_stream,
	input wire [3:0][ABITS-1:0] syscall_vector,
	input wire [3:0][ABITS-1:0] kernel_vector,
	input wire [ABITS-1:0] pc_stack_top,
	output pc_address_t dstpc,
	output pc_address_t misspc,
	output pc_stream_t kept_stream,
	output logic alloc_new_stream,
	output logic miss
);

	// displacement in bytes, halfword count shifted up one
	logic [ABITS-1:0] disp_ext;
	// address of the instruction after the branch
	logic [ABITS-1:0] fall_pc;
	// vector slot chosen by the mode the trap enters
	logic [1:0] vec_idx;

	assign disp_ext = {{(ABITS - 25){ent.disp[23]}}, ent.disp, 1'b0};
	assign fall_pc = ent.pc.pc + ABITS'(INSN_LEN);
	assign vec_idx = fn_next_om(ent.om);

	always_comb
	begin
		// defaults, a miss lands on the reset address in stream one
		misspc.pc = RSTPC;
		misspc.stream = 7'd1;
		// dstpc inherits the stream of the branch unless a case says otherwise
		dstpc = ent.pc;
		kept_stream = 7'd0;
		alloc_new_stream = 1'b0;
		miss = 1'b1;

		// ==================================================
		// destination by kind
		// ==================================================
		case (ent.kind)
			BK_BCC:
				dstpc.pc = ent.md ? ent.argc : ent.pc.pc + disp_ext;
			BK_BSR:
			begin
				dstpc.pc = ent.pc.pc + disp_ext;
				dstpc.stream = new_stream;
				alloc_new_stream = 1'b1;
			end
			BK_JSR:
			begin
				// absolute target taken straight from the displacement
				dstpc.pc = disp_ext;
				dstpc.stream = new_stream;
				alloc_new_stream = 1'b1;
			end
			BK_SYS:
			begin
				// codes 2 and 34 are system calls, all others go to the kernel
				if (ent.sysno == 6'h02 || ent.sysno == 6'h22)
					dstpc.pc = syscall_vector[vec_idx];
				else
					dstpc.pc = kernel_vector[vec_idx];
				dstpc.stream = new_stream;
				alloc_new_stream = 1'b1;
			end
			BK_RET:
				dstpc.pc = ent.arga;
			BK_ERET:
				dstpc.pc = pc_stack_top;
			default:
				dstpc.pc = RSTPC;
		endcase

		// ==================================================
		// recovery path
		// ==================================================
		if (ent.kind == BK_BCC)
		begin
			// predicted bit against actual outcome
			case ({ent.bt, ent.takb})
				2'b00:
				begin
					// correctly predicted not taken
					misspc.pc = dstpc.pc;
					miss = 1'b0;
				end
				2'b01:
				begin
					// predicted not taken but taken, the target starts a new stream
					misspc.pc = dstpc.pc;
					misspc.stream = new_stream;
					alloc_new_stream = 1'b1;
					kept_stream = ent.pc.stream;
				end
				2'b10:
				begin
					// predicted taken but fell through
					misspc.pc = fall_pc;
					misspc.stream = new_stream;
					alloc_new_stream = 1'b1;
					kept_stream = dstpc.stream;
				end
				default:
				begin
					// correctly predicted taken
					misspc.pc = fall_pc;
					misspc.stream = ent.pc.stream;
					miss = 1'b0;
				end
			endcase
		end
		else
		begin
			// every other kind always redirects to its destination
			misspc = dstpc;
		end
	end

endmodule

`default_nettype wire

/* verilog/branch_redirect.sv */
// drains the branch queue, allocates stream ids and registers one redirect per branch
`timescale 1ns/1ns
`default_nettype none

module branch_redirect
	import branch_pkg::*;
#(
	parameter int ABITS = 32
)
(
	input wire clk,
	input wire rst_n,
	input wire br_entry_t head,
	input wire empty,
	input wire hold,
	input wire [3:0][ABITS-1:0] syscall_vector,
	input wire [3:0][ABITS-1:0] kernel_vector,
	input wire [ABITS-1:0] pc_stack_top,
	output logic pop,
	output logic redir_valid,
	output redirect_t redir
);

	// next stream id handed out, never zero
	pc_stream_t stream_ctr;
	pc_address_t dstpc;
	pc_address_t misspc;
	pc_stream_t kept_stream;
	logic alloc_new_stream;
	logic miss;

	// take the head whenever there is one and the front end is listening
	assign pop = !empty && !hold;

	branchmiss_pc #(
		.ABITS(ABITS)
	) u_branchmiss_pc (
		.ent(head),
		.new_stream(stream_ctr),
		.syscall_vector(syscall_vector),
		.kernel_vector(kernel_vector),
		.pc_stack_top(pc_stack_top),
		.dstpc(dstpc),
		.misspc(misspc),
		.kept_stream(kept_stream),
		.alloc_new_stream(alloc_new_stream),
		.miss(miss)
	);

	// ==================================================
	// stream allocation and output register
	// ==================================================

	// the counter skips zero when it wraps
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			stream_ctr <= 7'd1;
			redir_valid <= 1'b0;
		end
		else
		begin
			redir_valid <= pop;
			if (pop && alloc_new_stream)
				stream_ctr <= (stream_ctr == 7'd127) ? 7'd1 : stream_ctr + 7'd1;
		end
	end

	// redirect payload, meaningful only alongside redir_valid
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			redir.misspc <= misspc;
			redir.dstpc <= dstpc;
			redir.kept_stream <= kept_stream;
			redir.miss <= miss;
		end
	end

endmodule

`default_nettype wire

/* verilog/branch_resolve_top.sv */
// top of the branch resolution back end, connects capture, queue and redirect
`timescale 1ns/1ns
`default_nettype none

module branch_resolve_top
	import branch_pkg::*;
#(
	parameter int ABITS = 32,
	parameter int DEPTH = 4
)
(
	input wire clk,
	input wire rst_n,
	// issue side from the reservation station
	input wire issue,
	input wire br_kind_e kind,
	input wire br_cond_e cond,
	input wire md,
	input wire pc_address_t pc,
	input wire [23:0] disp,
	input wire [ABITS-1:0] arga,
	input wire [ABITS-1:0] argb,
	input wire [ABITS-1:0] argc,
	input wire [1:0] om,
	input wire [5:0] sysno,
	input wire bt,
	output logic full,
	// front end side
	input wire hold,
	input wire [3:0][ABITS-1:0] syscall_vector,
	input wire [3:0][ABITS-1:0] kernel_vector,
	input wire [ABITS-1:0] pc_stack_top,
	output logic redir_valid,
	output redirect_t redir
);

	logic push;
	logic pop;
	logic empty;
	br_entry_t entry;
	br_entry_t head;

	branch_capture #(
		.ABITS(ABITS)
	) u_capture (
		.clk(clk),
		.rst_n(rst_n),
		.issue(issue),
		.kind(kind),
		.cond(cond),
		.md(md),
		.pc(pc),
		.disp(disp),
		.arga(arga),
		.argb(argb),
		.argc(argc),
		.om(om),
		.sysno(sysno),
		.bt(bt),
		.push(push),
		.entry(entry)
	);

	// holds evaluated branches while the front end asserts hold
	branch_queue #(
		.T(br_entry_t),
		.DEPTH(DEPTH)
	) u_queue (
		.clk(clk),
		.rst_n(rst_n),
		.push(push),
		.pop(pop),
		.din(entry),
		.head(head),
		.empty(empty),
		.full(full)
	);

	branch_redirect #(
		.ABITS(ABITS)
	) u_redirect (
		.clk(clk),
		.rst_n(rst_n),
		.head(head),
		.empty(empty),
		.hold(hold),
		.syscall_vector(syscall_vector),
		.kernel_vector(kernel_vector),
		.pc_stack_top(pc_stack_top),
		.pop(pop),
		.redir_valid(redir_valid),
		.redir(redir)
	);

endmodule

`default_nettype wire

/* dv/branch_resolve_props.sv */
// concurrent checks on queue occupancy and redirect output, bound into queue and redirect
`timescale 1ns/1ns
`default_nettype none

module branch_resolve_props
(
	input wire clk,
	input wire rst_n,
	input wire push,
	input wire full,
	input wire pop,
	input wire empty,
	input wire redir_valid,
	input wire miss,
	input wire [6:0] miss_stream
);

	// a push into a full queue would be dropped
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
		else $error("push while the branch queue is full");

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
		else $error("pop while the branch queue is empty");

	// the cycle after a reset edge carries no redirect
	a_quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !redir_valid)
		else $error("redir_valid high in the cycle after reset");

	// a miss must always name a stream to recover into
	a_miss_has_stream: assert property (@(posedge clk) disable iff (!rst_n)
		(redir_valid && miss) |-> (miss_stream != 7'd0))
		else $error("miss redirect with stream zero");

endmodule

// ==================================================
// attachment points
// ==================================================

bind branch_queue branch_resolve_props u_queue_props (
	.clk(clk),
	.rst_n(rst_n),
	.push(push),
	.full(full),
	.pop(pop),
	.empty(empty),
	.redir_valid(1'b0),
	.miss(1'b0),
	.miss_stream(7'd1)
);

bind branch_redirect branch_resolve_props u_redirect_props (
	.clk(clk),
	.rst_n(rst_n),
	.push(1'b0),
	.full(1'b0),
	.pop(1'b0),
	.empty(1'b0),
	.redir_valid(redir_valid),
	.miss(redir.miss),
	.miss_stream(redir.misspc.stream)
);

`default_nettype wire

/* dv/branch_resolve_tb.sv */
// testbench for branch resolution, replays the input data file and checks every redirect
`timescale 1ns/1ns
`default_nettype none

module branch_resolve_tb
	import branch_pkg::*;
;

	localparam int MAX_LINES = 64;
	localparam int NCOLS = 18;
	localparam int DEPTH = 4;

	// one expected redirect, compared when redir_valid shows up
	typedef struct packed {
		logic [31:0] misspc;
		logic [6:0] miss_stream;
		logic [31:0] dstpc;
		logic [6:0] kept_stream;
		logic miss;
		// set when the branch went in with hold low and nothing queued ahead of it
		logic timed;
		logic [31:0] issue_cyc;
	} expect_t;

	logic clk;
	logic rst_n;
	logic issue;
	br_kind_e kind;
	br_cond_e cond;
	logic md;
	pc_address_t pc;
	logic [23:0] disp;
	logic [31:0] arga;
	logic [31:0] argb;
	logic [31:0] argc;
	logic [1:0] om;
	logic [5:0] sysno;
	logic bt;
	logic full;
	logic hold;
	logic [3:0][31:0] syscall_vector;
	logic [3:0][31:0] kernel_vector;
	logic [31:0] pc_stack_top;
	logic redir_valid;
	redirect_t redir;

	// stimulus rows, columns in the order of the data file
	logic [31:0] stim [MAX_LINES][NCOLS];
	int n_lines = 0;
	expect_t exp_q[$];
	logic [31:0] cyc = '0;
	logic [31:0] limit = 32'd1000;
	logic prev_hold;

	branch_resolve_top #(
		.ABITS(32),
		.DEPTH(DEPTH)
	) u_dut (.*);

	always #5 clk = ~clk;

	// ==================================================
	// failure reporting and checks
	// ==================================================

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// the cycle counter ends a run that stops making progress
	always @(posedge clk)
	begin
		cyc <= cyc + 32'd1;
		if (cyc >= limit)
			fail_run("timeout, the run went past its cycle limit without finishing");
	end

	// matches one redirect against the oldest outstanding branch
	task automatic check_redirect();
		expect_t e;
		if (redir_valid)
		begin
			if (exp_q.size() == 0)
				fail_run("a redirect came out with no branch outstanding");
			else
			begin
				e = exp_q.pop_front();
				compare("redir.misspc.pc", 32'(redir.misspc.pc), e.misspc);
				compare("redir.misspc.stream", 32'(redir.misspc.stream), 32'(e.miss_stream));
				compare("redir.dstpc.pc", 32'(redir.dstpc.pc), e.dstpc);
				compare("redir.kept_stream", 32'(redir.kept_stream), 32'(e.kept_stream));
				compare("redir.miss", 32'(redir.miss), 32'(e.miss));
				// sampled at the falling edge so the issue edge counts as cycle zero
				if (e.timed)
					compare("redir_valid latency", cyc - e.issue_cyc, 32'd2);
			end
		end
	endtask

	// ==================================================
	// stimulus
	// ==================================================

	// lines starting with # and blank lines are skipped
	task automatic read_stimulus();
		int fd;
		int got;
		string line;
		fd = $fopen("dv/branch_input.txt", "r");
		if (fd == 0)
			fail_run("could not open dv/branch_input.txt for reading");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#")
				begin
					if (n_lines == MAX_LINES)
						fail_run("too many lines in dv/branch_input.txt");
					got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						stim[n_lines][0], stim[n_lines][1], stim[n_lines][2], stim[n_lines][3],
						stim[n_lines][4], stim[n_lines][5], stim[n_lines][6], stim[n_lines][7],
						stim[n_lines][8], stim[n_lines][9], stim[n_lines][10], stim[n_lines][11],
						stim[n_lines][12], stim[n_lines][13], stim[n_lines][14],
						stim[n_lines][15], stim[n_lines][16], stim[n_lines][17]);
					if (got != NCOLS)
						fail_run("a line of dv/branch_input.txt does not have 18 columns");
					else
						n_lines++;
				end
			end
			$fclose(fd);
		end
	endtask

	// one falling edge, outputs are checked before new inputs go out
	task automatic tick();
		int queued;
		@(negedge clk);
		check_redirect();
		// a branch sampled at the last edge still sits in capture, the rest are queued
		queued = exp_q.size() - int'(issue);
		compare("full", 32'(full), 32'(queued == DEPTH));
		issue = 1'b0;
	endtask

	task automatic issue_line(input int i);
		expect_t e;
		tick();
		while (full)
			tick();
		hold = stim[i][0][0];
		kind = br_kind_e'(stim[i][1][2:0]);
		cond = br_cond_e'(stim[i][2][1:0]);
		md = stim[i][3][0];
		pc.pc = stim[i][4];
		pc.stream = stim[i][5][6:0];
		disp = stim[i][6][23:0];
		arga = stim[i][7];
		argb = stim[i][8];
		argc = stim[i][9];
		om = stim[i][10][1:0];
		sysno = stim[i][11][5:0];
		bt = stim[i][12][0];
		issue = 1'b1;
		e.misspc = stim[i][13];
		e.miss_stream = stim[i][14][6:0];
		e.dstpc = stim[i][15];
		e.kept_stream = stim[i][16][6:0];
		e.miss = stim[i][17][0];
		e.timed = !stim[i][0][0] && !prev_hold;
		// the next rising edge samples the issue
		e.issue_cyc = cyc + 32'd1;
		exp_q.push_back(e);
	endtask

	// lets every outstanding branch come out before the hold level changes
	task automatic drain();
		while (exp_q.size() != 0)
			tick();
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		issue = 1'b0;
		kind = BK_NONE;
		cond = EQ;
		md = 1'b0;
		pc = '0;
		disp = '0;
		arga = '0;
		argb = '0;
		argc = '0;
		om = '0;
		sysno = '0;
		bt = 1'b0;
		hold = 1'b0;
		pc_stack_top = 32'h0000_3000;
		// each mode gets its own vector so a wrong index shows up
		for (int m = 0; m < 4; m++)
		begin
			syscall_vector[m] = 32'h0000_1000 + 32'(m) * 32'h100;
			kernel_vector[m] = 32'h0000_2000 + 32'(m) * 32'h100;
		end
		prev_hold = 1'b0;
		read_stimulus();
		limit = 32'(4 * n_lines + 50);
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_lines; i++)
		begin
			if (stim[i][0][0] && !prev_hold)
				drain();
			issue_line(i);
			// the first line after a held burst releases it, then the queue empties
			if (!stim[i][0][0] && prev_hold)
				drain();
			prev_hold = stim[i][0][0];
		end
		drain();
		// a few quiet cycles catch a duplicated redirect
		repeat (5) tick();
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/branch_input.txt */
# hold kind cond md pc pc_stream disp arga argb argc om sysno bt, all hex
# then expected misspc.pc misspc.stream dstpc.pc kept_stream miss
0 1 0 0 00001000 05 000010 00000005 00000005 00000000 0 00 1  00001006 05 00001020 00 0
0 1 1 0 00002000 05 000008 00000005 00000005 00000000 0 00 0  00002010 01 00002010 00 0
0 1 2 0 00003000 06 fffff8 ffffffff 00000001 00000000 0 00 0  00002ff0 01 00002ff0 06 1
0 1 3 1 00004000 07 000000 00000001 00000002 00004444 0 00 1  00004006 02 00004444 07 1
0 2 0 0 00005000 07 000100 00000000 00000000 00000000 0 00 0  00005200 03 00005200 00 1
0 3 0 0 00006000 07 012345 00000000 00000000 00000000 0 00 0  0002468a 04 0002468a 00 1
0 4 0 0 00007000 07 000000 00000000 00000000 00000000 0 02 0  00001100 05 00001100 00 1
0 4 0 0 00007100 07 000000 00000000 00000000 00000000 3 22 0  00001300 06 00001300 00 1
0 4 0 0 00007200 07 000000 00000000 00000000 00000000 2 05 0  00002300 07 00002300 00 1
0 4 0 0 00007300 07 000000 00000000 00000000 00000000 1 10 0  00002200 08 00002200 00 1
0 5 0 0 00007400 09 000000 00007777 00000000 00000000 0 00 0  00007777 09 00007777 00 1
0 6 0 0 00008000 0a 000000 00000000 00000000 00000000 0 00 0  00003000 0a 00003000 00 1
1 2 0 0 00009000 0b 000002 00000000 00000000 00000000 0 00 0  00009004 09 00009004 00 1
1 1 0 0 0000a000 0b 000004 00000003 00000004 00000000 0 00 0  0000a008 01 0000a008 00 0
1 3 0 0 0000a100 0b 000800 00000000 00000000 00000000 0 00 0  00001000 0a 00001000 00 1
0 4 0 0 0000a200 0b 000000 00000000 00000000 00000000 2 02 0  00001300 0b 00001300 00 1
0 1 1 0 0000b000 0c 000006 00000001 00000002 00000000 0 00 1  0000b006 0c 0000b00c 00 0
0 5 0 0 0000c000 0c 000000 0000cccc 00000000 00000000 0 00 0  0000cccc 0c 0000cccc 00 1

/* files.f */
verilog/branch_pkg.sv
verilog/branch_queue.sv
verilog/branch_capture.sv
verilog/branchmiss_pc.sv
verilog/branch_redirect.sv
verilog/branch_resolve_top.sv
dv/branch_resolve_props.sv
dv/branch_resolve_tb.sv

/* Makefile */
# Verilator build and run of the branch resolution testbench
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert -Wno-fatal -j 0
TOP := branch_resolve_tb
FILELIST := files.f
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
